// ==== include/icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Fetch address and instruction word.
`define ICACHE_ADDR_W 32
`define ICACHE_DATA_W 32

// Cache geometry.
`define ICACHE_LINES 16
`define ICACHE_LINE_BYTES 16
`define ICACHE_BEATS (`ICACHE_LINE_BYTES / (`ICACHE_DATA_W / 8))

`endif

// ==== verilog/icache_addr_pkg.sv ====
`default_nettype none

`include "icache_settings.svh"

package icache_addr_pkg;

    localparam int OFFSET_W = $clog2(`ICACHE_LINE_BYTES);  // Byte within a line.
    localparam int INDEX_W  = $clog2(`ICACHE_LINES);
    localparam int TAG_W    = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // Same fetch address, seen as one word or split for the lookup.
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] word;
        addr_fields_t              fields;
    } fetch_addr_u;

endpackage

`default_nettype wire

// ==== verilog/icache_bus_pkg.sv ====
`default_nettype none

`include "icache_settings.svh"

package icache_bus_pkg;

    typedef struct packed {
        icache_addr_pkg::fetch_addr_u addr;
        logic                         is_fence;  // Set for fence.i, addr unused.
    } fetch_req_t;

    typedef struct packed {
        logic [`ICACHE_DATA_W-1:0] data;
        logic                      hit;
    } fetch_rsp_t;

    // Lowest address word sits in the lowest bits.
    typedef logic [`ICACHE_LINE_BYTES*8-1:0] line_t;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] base;  // Line aligned.
    } fill_req_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_req_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_req_port (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_req,
    input  icache_addr_pkg::fetch_addr_u fetch_addr,
    input  logic                         fence_i,
    input  logic                         done,
    output logic                         pend,
    output icache_bus_pkg::fetch_req_t   pend_req
);

    import icache_bus_pkg::*;

    fetch_req_t next_req;
    logic       accept;

    // Fence wins when both strobes come together.
    always_comb begin
        next_req.addr     = fetch_addr;
        next_req.is_fence = fence_i;
    end

    // A new strobe may land in the same cycle that done retires the old one.
    assign accept = (fetch_req || fence_i) && (!pend || done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend <= 1'b0;
        end else if (accept) begin
            pend <= 1'b1;
        end else if (done) begin
            pend <= 1'b0;
        end
    end

    // Held steady for the whole refill.
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_req <= next_req;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icache_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module icache_core (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pend,
    input  icache_bus_pkg::fetch_req_t pend_req,
    output logic                       done,
    output logic                       rsp_valid,
    output icache_bus_pkg::fetch_rsp_t rsp,
    output logic                       fill_start,
    output icache_bus_pkg::fill_req_t  fill_req,
    input  logic                       fill_done,
    input  icache_bus_pkg::line_t      fill_line
);

    import icache_addr_pkg::*;
    import icache_bus_pkg::*;

    localparam int WORD_LSB = $clog2(`ICACHE_DATA_W / 8);
    localparam int SEL_W    = OFFSET_W - WORD_LSB;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        REFILL,
        FENCE
    } state_t;

    state_t state;

    logic [TAG_W-1:0]        tag_q   [`ICACHE_LINES];
    line_t                   data_q  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid_q;

    addr_fields_t             fld;
    logic [SEL_W-1:0]         word_sel;
    logic                     hit;
    line_t                    cur_line;

    assign fld      = pend_req.addr.fields;
    assign word_sel = fld.offset[OFFSET_W-1:WORD_LSB];
    assign cur_line = data_q[fld.index];
    assign hit      = valid_q[fld.index] && (tag_q[fld.index] == fld.tag);

    assign done = rsp_valid;  // Retires the pending request.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            rsp_valid  <= 1'b0;
            fill_start <= 1'b0;
            valid_q    <= '0;
        end else begin
            rsp_valid  <= 1'b0;
            fill_start <= 1'b0;
            case (state)
                IDLE: begin
                    // done still high means pend is about to drop or reload.
                    if (pend && !rsp_valid) begin
                        state <= pend_req.is_fence ? FENCE : COMPARE;
                    end
                end
                COMPARE: begin
                    if (hit) begin
                        rsp_valid <= 1'b1;
                        state     <= IDLE;
                    end else begin
                        fill_start <= 1'b1;
                        state      <= REFILL;
                    end
                end
                REFILL: begin
                    if (fill_done) begin
                        valid_q[fld.index] <= 1'b1;
                        rsp_valid          <= 1'b1;
                        state              <= IDLE;
                    end
                end
                FENCE: begin
                    valid_q   <= '0;  // Drops every line.
                    rsp_valid <= 1'b1;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            COMPARE: begin
                rsp.data      <= cur_line[word_sel*`ICACHE_DATA_W +: `ICACHE_DATA_W];
                rsp.hit       <= hit;
                fill_req.base <= {pend_req.addr.word[`ICACHE_ADDR_W-1:OFFSET_W],
                                  {OFFSET_W{1'b0}}};
            end
            REFILL: begin
                if (fill_done) begin
                    tag_q[fld.index]  <= fld.tag;
                    data_q[fld.index] <= fill_line;
                    // Answer straight from the fresh line.
                    rsp.data <= fill_line[word_sel*`ICACHE_DATA_W +: `ICACHE_DATA_W];
                    rsp.hit  <= 1'b0;
                end
            end
            FENCE: rsp <= '0;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/line_fill_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module line_fill_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            fill_start,
    input  icache_bus_pkg::fill_req_t       fill_req,
    output logic                            fill_done,
    output icache_bus_pkg::line_t           fill_line,
    output logic                            mem_rd,
    output logic [`ICACHE_ADDR_W-1:0]       mem_addr,
    input  logic                            mem_rd_valid,
    input  logic [`ICACHE_DATA_W-1:0]       mem_rd_data
);

    import icache_bus_pkg::*;

    localparam int BEAT_W    = $clog2(`ICACHE_BEATS);
    localparam int BYTE_BITS = $clog2(`ICACHE_DATA_W / 8);

    fill_req_t         base_q;
    logic              busy;
    logic [BEAT_W-1:0] beat;
    logic [BEAT_W-1:0] beat_next;
    logic              start;
    logic              last_beat;

    assign start     = fill_start && !busy;
    assign beat_next = beat + BEAT_W'(1);
    assign last_beat = (beat == BEAT_W'(`ICACHE_BEATS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            beat      <= '0;
            mem_rd    <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            mem_rd    <= 1'b0;
            fill_done <= 1'b0;
            if (start) begin
                busy   <= 1'b1;
                beat   <= '0;
                mem_rd <= 1'b1;
            end else if (busy && mem_rd_valid) begin
                if (last_beat) begin
                    busy      <= 1'b0;
                    fill_done <= 1'b1;
                end else begin
                    beat   <= beat_next;
                    mem_rd <= 1'b1;  // One read in flight at a time.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            base_q   <= fill_req;
            mem_addr <= fill_req.base;
        end else if (busy && mem_rd_valid) begin
            fill_line[beat*`ICACHE_DATA_W +: `ICACHE_DATA_W] <= mem_rd_data;
            mem_addr <= base_q.base + (`ICACHE_ADDR_W'(beat_next) << BYTE_BITS);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module icache_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_req,
    input  icache_addr_pkg::fetch_addr_u fetch_addr,
    input  logic                         fence_i,
    output logic                         fetch_valid,
    output icache_bus_pkg::fetch_rsp_t   fetch_rsp,
    output logic                         mem_rd,
    output logic [`ICACHE_ADDR_W-1:0]    mem_addr,
    input  logic                         mem_rd_valid,
    input  logic [`ICACHE_DATA_W-1:0]    mem_rd_data
);

    import icache_bus_pkg::*;

    logic       pend;
    fetch_req_t pend_req;
    logic       done;
    logic       fill_start;
    fill_req_t  fill_req;
    logic       fill_done;
    line_t      fill_line;

    fetch_req_port u_port (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fence_i    (fence_i),
        .done       (done),
        .pend       (pend),
        .pend_req   (pend_req)
    );

    icache_core u_core (
        .clk        (clk),
        .rst        (rst),
        .pend       (pend),
        .pend_req   (pend_req),
        .done       (done),
        .rsp_valid  (fetch_valid),
        .rsp        (fetch_rsp),
        .fill_start (fill_start),
        .fill_req   (fill_req),
        .fill_done  (fill_done),
        .fill_line  (fill_line)
    );

    line_fill_unit u_fill (
        .clk          (clk),
        .rst          (rst),
        .fill_start   (fill_start),
        .fill_req     (fill_req),
        .fill_done    (fill_done),
        .fill_line    (fill_line),
        .mem_rd       (mem_rd),
        .mem_addr     (mem_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data)
    );

endmodule

`default_nettype wire

// ==== dv/tb_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module tb_mem_model #(
    parameter logic [`ICACHE_DATA_W-1:0] PATTERN = '0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_rd,
    input  logic [`ICACHE_ADDR_W-1:0] mem_addr,
    output logic                      mem_rd_valid,
    output logic [`ICACHE_DATA_W-1:0] mem_rd_data
);

    logic                      busy;
    logic [`ICACHE_ADDR_W-1:0] addr_q;
    int unsigned               delay;

    // Answers on the falling edge, one read at a time.
    initial begin
        busy         = 1'b0;
        delay        = 0;
        addr_q       = '0;
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        forever begin
            @(negedge clk);
            mem_rd_valid = 1'b0;
            if (rst) begin
                busy = 1'b0;
            end else if (busy) begin
                if (delay == 0) begin
                    busy         = 1'b0;
                    mem_rd_valid = 1'b1;
                    mem_rd_data  = addr_q ^ PATTERN;  // Every address bit shows in the word.
                end else begin
                    delay = delay - 1;
                end
            end else if (mem_rd) begin
                busy   = 1'b1;
                addr_q = mem_addr;
                delay  = $urandom_range(5, 0);  // 1 to 6 cycles until mem_rd_valid.
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/icache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_settings.svh"

module icache_tb;

    import icache_addr_pkg::*;
    import icache_bus_pkg::*;

    localparam logic [`ICACHE_DATA_W-1:0] MEM_PATTERN = 32'h5a3c_96e1;
    localparam int HIT_LAT = 3;  // Falling edges from strobe to fetch_valid.
    localparam int TIMEOUT = 200;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      fetch_req;
    logic                      fence_i;
    logic                      fetch_valid;
    logic                      mem_rd;
    logic                      mem_rd_valid;
    fetch_addr_u               fetch_addr;
    fetch_rsp_t                fetch_rsp;
    logic [`ICACHE_ADDR_W-1:0] mem_addr;
    logic [`ICACHE_DATA_W-1:0] mem_rd_data;

    logic [`ICACHE_LINES-1:0]  ref_valid;  // Reference cache state.
    logic [TAG_W-1:0]          ref_tag [`ICACHE_LINES];
    logic [TAG_W-1:0]          tag_pool [4];
    logic [`ICACHE_ADDR_W-1:0] line_base;  // Line of the request in flight.
    int                        req_count = 0;
    int                        rsp_count = 0;
    int                        rd_count  = 0;

    icache_top UUT (.*);
    tb_mem_model #(.PATTERN(MEM_PATTERN)) mem (.*);

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (!rst && fetch_valid) rsp_count++;
    end

    // Reads walk the missed line from its lowest word up.
    always @(negedge clk) begin
        if (!rst && mem_rd) begin
            compare("mem_addr", 64'(line_base + 32'(rd_count * 4)), 64'(mem_addr));
            rd_count++;
        end
    end

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic wait_response(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            fetch_req = 1'b0;
            fence_i   = 1'b0;
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("No response on fetch_valid within %0d cycles", TIMEOUT);
                $display("TEST FAIL");
                $fatal(1, "response timeout");
            end
        end while (!fetch_valid);
    endtask

    function automatic logic [31:0] make_addr(input logic [TAG_W-1:0] tag, input int index,
                                              input int word);
        fetch_addr_u f;
        f.fields.tag    = tag;
        f.fields.index  = INDEX_W'(index);
        f.fields.offset = OFFSET_W'(word * 4);
        return f.word;
    endfunction

    // A drops count above zero keeps strobing while the miss is pending.
    task automatic run_request(input logic fence, input logic [31:0] addr, input int drops);
        fetch_addr_u f;
        logic        exp_hit;
        int          cycles;
        f.word     = addr;
        exp_hit    = !fence && ref_valid[f.fields.index]
                     && (ref_tag[f.fields.index] == f.fields.tag);
        line_base  = {addr[31:OFFSET_W], OFFSET_W'(0)};
        rd_count   = 0;
        fetch_addr = f;
        fetch_req  = !fence;
        fence_i    = fence;
        req_count++;
        repeat (drops) begin
            @(negedge clk);
            fetch_addr.word = ~addr;
        end
        wait_response(cycles);
        compare("fetch_rsp.hit", 64'(exp_hit), 64'(fetch_rsp.hit));
        compare("fetch_rsp.data", fence ? 64'h0 : 64'(addr ^ MEM_PATTERN), 64'(fetch_rsp.data));
        compare("mem_rd count", (fence || exp_hit) ? 64'h0 : 64'(`ICACHE_BEATS),
                64'(rd_count));
        if (fence || exp_hit) begin
            compare("fetch_valid latency", 64'(HIT_LAT), 64'(cycles));
        end
        if (fence) begin
            ref_valid = '0;
        end else begin
            ref_valid[f.fields.index] = 1'b1;
            ref_tag[f.fields.index]   = f.fields.tag;
        end
    endtask

    initial begin
        void'($urandom(32'he0ba_161f));
        tag_pool   = '{24'h000010, 24'h0003a7, 24'h01c2f0, 24'h7f0001};
        rst        = 1'b1;
        fetch_req  = 1'b0;
        fence_i    = 1'b0;
        fetch_addr = '0;
        ref_valid  = '0;
        line_base  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare("fetch_valid", 64'h0, 64'(fetch_valid));
        compare("mem_rd", 64'h0, 64'(mem_rd));

        for (int i = 0; i < `ICACHE_LINES; i++) begin
            run_request(1'b0, make_addr(tag_pool[0], i, i % 4), 0);  // Cold misses.
        end
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            run_request(1'b0, make_addr(tag_pool[0], i, 3 - i % 4), 0);
        end

        // Same index with a new tag, then the old line comes back.
        run_request(1'b0, make_addr(tag_pool[1], 5, 2), 0);
        run_request(1'b0, make_addr(tag_pool[0], 5, 2), 0);

        run_request(1'b1, '0, 0);
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            run_request(1'b0, make_addr(tag_pool[0], i, 1), 0);
        end

        for (int n = 0; n < 2000; n++) begin
            if ($urandom_range(99, 0) < 3) begin
                run_request(1'b1, '0, 0);
            end else begin
                run_request(1'b0, make_addr(tag_pool[2'($urandom_range(3, 0))],
                                            $urandom_range(15, 0), $urandom_range(3, 0)), 0);
            end
        end

        run_request(1'b1, '0, 0);
        run_request(1'b0, make_addr(tag_pool[2], 9, 2), 3);
        repeat (60) @(negedge clk);
        compare("fetch_valid count", 64'(req_count), 64'(rsp_count));
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== icache_sys.f ====
+incdir+include
verilog/icache_addr_pkg.sv
verilog/icache_bus_pkg.sv
verilog/fetch_req_port.sv
verilog/icache_core.sv
verilog/line_fill_unit.sv
verilog/icache_top.sv
dv/tb_mem_model.sv
dv/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f icache_sys.f --top-module icache_tb -o icache_sim
./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
